// ==== flist.f ====
hdl/cpe_pkg.sv
hdl/cpe_inst_mem.sv
hdl/cpe_data_mem.sv
hdl/cpe_complex_alu.sv
hdl/cpe_pe.sv
hdl/cpe_sample_scatter.sv
hdl/cpe_result_gather.sv
hdl/cpe_array_top.sv
test/tb_cpe_array.sv

// ==== Bender.yml ====
package:
  name: cpe_array

sources:
  - files:
      - hdl/cpe_pkg.sv
      - hdl/cpe_inst_mem.sv
      - hdl/cpe_data_mem.sv
      - hdl/cpe_complex_alu.sv
      - hdl/cpe_pe.sv
      - hdl/cpe_sample_scatter.sv
      - hdl/cpe_result_gather.sv
      - hdl/cpe_array_top.sv
  - target: test
    files:
      - test/tb_cpe_array.sv

// ==== test/tb_cpe_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpe_array;

    // 16 + 8*4 + 20 cycles per block, 17 blocks over all tests
    localparam int NUM_BLOCKS      = 17;
    localparam int BLOCK_CYCLES    = 16 + 8 * 4 + 20;
    localparam int WATCHDOG_CYCLES = NUM_BLOCKS * BLOCK_CYCLES + 1000;

    logic                clk;
    logic                rst_n;
    logic                sample_v;
    cpe_pkg::cpx_t       sample;
    logic                inst_v;
    cpe_pkg::inst_t      inst;
    logic                result_v;
    cpe_pkg::cpx_t       result;
    cpe_pkg::pe_idx_t    result_pe;
    logic                busy;

    // program and sample buffers shared by stimulus and model
    cpe_pkg::inst_t      prog [cpe_pkg::IMEM_DEPTH];
    cpe_pkg::cpx_t       blk  [cpe_pkg::NUM_PE * cpe_pkg::REG_NUM];
    cpe_pkg::cpx_t       exp_q [cpe_pkg::NUM_PE][$];
    int                  next_pe;
    string               test_name;

    // snapshot of the expected head, taken mid-cycle
    logic                exp_avail;
    cpe_pkg::cpx_t       exp_value;

    int                  mismatch_cnt;
    int                  unexpected_cnt;
    int                  other_cnt;

    cpe_array_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_v  (sample_v),
        .sample    (sample),
        .inst_v    (inst_v),
        .inst      (inst),
        .result_v  (result_v),
        .result    (result),
        .result_pe (result_pe),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference arithmetic
    ////////////////////////////////////////////////////////////

    // op | emit | wb | a | b | dst
    function automatic cpe_pkg::inst_t make_inst(input logic [1:0] op, input logic emit,
                                                 input logic wb, input logic [3:0] a,
                                                 input logic [3:0] b, input logic [3:0] d);
        return {op, emit, wb, a, b, d};
    endfunction

    function automatic cpe_pkg::cpx_t cpx_add(input cpe_pkg::cpx_t a, input cpe_pkg::cpx_t b);
        return {a[31:16] + b[31:16], a[15:0] + b[15:0]};
    endfunction

    function automatic cpe_pkg::cpx_t cpx_sub(input cpe_pkg::cpx_t a, input cpe_pkg::cpx_t b);
        return {a[31:16] - b[31:16], a[15:0] - b[15:0]};
    endfunction

    // full products, arithmetic shift by 15, low 16 bits
    function automatic cpe_pkg::cpx_t cpx_mul(input cpe_pkg::cpx_t a, input cpe_pkg::cpx_t b);
        longint ar;
        longint ai;
        longint br;
        longint bi;
        longint re;
        longint im;
        ar = longint'($signed(a[31:16]));
        ai = longint'($signed(a[15:0]));
        br = longint'($signed(b[31:16]));
        bi = longint'($signed(b[15:0]));
        re = (ar * br - ai * bi) >>> 15;
        im = (ar * bi + ai * br) >>> 15;
        return {re[15:0], im[15:0]};
    endfunction

    // sequential execution of prog over one block
    task automatic run_model(input int pe, input int base);
        cpe_pkg::cpx_t  regs [16];
        cpe_pkg::inst_t ins;
        cpe_pkg::cpx_t  r;
        logic [1:0]     op;
        for (int i = 0; i < 16; i++) begin
            regs[i] = blk[base + i];
        end
        for (int pc = 0; pc < cpe_pkg::IMEM_DEPTH; pc++) begin
            ins = prog[pc];
            op  = ins[15:14];
            if (op == cpe_pkg::OP_HALT) begin
                break;
            end
            case (op)
                cpe_pkg::OP_ADD: r = cpx_add(regs[ins[11:8]], regs[ins[7:4]]);
                cpe_pkg::OP_SUB: r = cpx_sub(regs[ins[11:8]], regs[ins[7:4]]);
                default:         r = cpx_mul(regs[ins[11:8]], regs[ins[7:4]]);
            endcase
            if (ins[12]) begin
                regs[ins[3:0]] = r;
            end
            if (ins[13]) begin
                exp_q[pe].push_back(r);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic load_program();
        for (int i = 0; i < cpe_pkg::IMEM_DEPTH; i++) begin
            @(posedge clk);
            #5;
            inst_v = 1'b1;
            inst   = prog[i];
        end
        @(posedge clk);
        #5;
        inst_v = 1'b0;
        // idle cycle, next load starts at slot 0 again
        @(posedge clk);
        #5;
    endtask

    task automatic send_samples(input int lo, input int hi);
        for (int i = lo; i <= hi; i++) begin
            @(posedge clk);
            #5;
            sample_v = 1'b1;
            sample   = blk[i];
        end
        @(posedge clk);
        #5;
        sample_v = 1'b0;
    endtask

    // n blocks back to back, PE order follows the scatter selector
    task automatic run_blocks(input int n);
        for (int b = 0; b < n; b++) begin
            run_model(next_pe, b * cpe_pkg::REG_NUM);
            next_pe = (next_pe + 1) % cpe_pkg::NUM_PE;
        end
        send_samples(0, n * cpe_pkg::REG_NUM - 1);
    endtask

    task automatic randomize_samples();
        for (int i = 0; i < cpe_pkg::NUM_PE * cpe_pkg::REG_NUM; i++) begin
            blk[i] = $urandom();
        end
    endtask

    task automatic wait_idle();
        repeat (2) @(posedge clk);
        @(negedge clk);
        while (busy !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    // leftovers mean lost results
    task automatic check_queues();
        for (int k = 0; k < cpe_pkg::NUM_PE; k++) begin
            assert (exp_q[k].size() == 0) else begin
                other_cnt++;
                $display("%0d results from PE %0d never came out in test %s",
                         exp_q[k].size(), k, test_name);
            end
            exp_q[k].delete();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // result checking
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        exp_avail = 1'b0;
        exp_value = '0;
        if (rst_n && result_v && (exp_q[result_pe].size() != 0)) begin
            exp_avail = 1'b1;
            exp_value = exp_q[result_pe].pop_front();
        end
    end

    a_result_expected: assert property (
        @(posedge clk) disable iff (!rst_n) result_v |-> exp_avail
    ) else begin
        unexpected_cnt++;
        $display("result from PE %0d arrived with nothing expected in test %s",
                 $sampled(result_pe), test_name);
    end

    a_result_match: assert property (
        @(posedge clk) disable iff (!rst_n) (result_v && exp_avail) |-> (result == exp_value)
    ) else begin
        mismatch_cnt++;
        $display("Error test=%s pe=%0d expected=%h actual=%h",
                 test_name, $sampled(result_pe), $sampled(exp_value), $sampled(result));
    end

    // first edge after reset release, before any stimulus
    a_quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (!result_v && !busy)
    ) else begin
        other_cnt++;
        $display("result_v or busy is high right after reset");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the array never went idle in test %s", test_name);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [15:0] spec [8];
        rst_n          = 1'b0;
        sample_v       = 1'b0;
        sample         = '0;
        inst_v         = 1'b0;
        inst           = '0;
        next_pe        = 0;
        mismatch_cnt   = 0;
        unexpected_cnt = 0;
        other_cnt      = 0;
        test_name      = "reset";
        void'($urandom(32'hcb69ce89));
        spec = '{16'h7fff, 16'h8000, 16'h8001, 16'h7ffe,
                 16'hc000, 16'h4000, 16'h0001, 16'hffff};
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;

        // partial block, nothing may come out yet
        test_name = "partial_block";
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_inst((i % 2 == 0) ? cpe_pkg::OP_ADD : cpe_pkg::OP_SUB, 1'b1,
                                1'b1, 4'(i), 4'(15 - i), 4'(i + 4));
        end
        load_program();
        randomize_samples();
        send_samples(0, 14);
        repeat (20) @(posedge clk);
        #5;
        assert (busy === 1'b1) else begin
            other_cnt++;
            $display("busy is low with a partial block loaded");
        end
        run_model(next_pe, 0);
        next_pe = (next_pe + 1) % cpe_pkg::NUM_PE;
        send_samples(15, 15);
        wait_idle();
        check_queues();

        // add and sub with emits on all PEs
        test_name = "add_sub";
        randomize_samples();
        run_blocks(4);
        wait_idle();
        check_queues();

        // products of values near plus and minus one
        test_name = "multiply";
        for (int i = 0; i < 16; i++) begin
            blk[i] = {spec[i % 8], spec[(i * 3 + 1) % 8]};
        end
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_inst(cpe_pkg::OP_MUL, 1'b1, 1'b0, 4'(i), 4'(15 - i), 4'd0);
        end
        load_program();
        run_blocks(1);
        wait_idle();
        check_queues();

        // each instruction reads the previous destination
        test_name = "dependent_chain";
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_inst(2'(i % 3 + 1), (i == 7), 1'b1,
                                (i == 0) ? 4'd0 : 4'(i + 1), 4'(15 - i), 4'(i + 2));
        end
        load_program();
        randomize_samples();
        run_blocks(2);
        wait_idle();
        check_queues();

        // halt in slot 3 stops the emits after it
        test_name = "halt";
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_inst((i < 3) ? cpe_pkg::OP_ADD : cpe_pkg::OP_SUB, 1'b1,
                                1'b1, 4'(i), 4'(i + 5), 4'(i + 8));
        end
        prog[3] = make_inst(cpe_pkg::OP_HALT, 1'b1, 1'b1, 4'd1, 4'd2, 4'd3);
        load_program();
        randomize_samples();
        run_blocks(1);
        wait_idle();
        check_queues();

        // reloaded program, second round
        test_name = "reload";
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_inst((i % 2 == 0) ? cpe_pkg::OP_MUL : cpe_pkg::OP_ADD, 1'b1,
                                (i % 3 == 0), 4'(2 * i), 4'(i + 1), 4'(i + 1));
        end
        load_program();
        randomize_samples();
        run_blocks(4);
        wait_idle();
        check_queues();

        // four gapless blocks, chained multiplies stretch each run past the next block
        // so PE outputs overlap in the gather
        test_name = "overlap";
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_inst(cpe_pkg::OP_MUL, 1'b1, 1'b1, 4'(i), 4'(i + 8), 4'(i + 1));
        end
        load_program();
        randomize_samples();
        run_blocks(4);
        wait_idle();
        check_queues();

        $display("errors: mismatches=%0d unexpected=%0d other=%0d",
                 mismatch_cnt, unexpected_cnt, other_cnt);
        if (mismatch_cnt + unexpected_cnt + other_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cpe_array_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpe_array_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sample_v,
    input  cpe_pkg::cpx_t    sample,
    input  logic             inst_v,
    input  cpe_pkg::inst_t   inst,
    output logic             result_v,
    output cpe_pkg::cpx_t    result,
    output cpe_pkg::pe_idx_t result_pe,
    output logic             busy
);

    logic [cpe_pkg::NUM_PE-1:0] load_v;
    cpe_pkg::cpx_t              load_data;
    logic                       loading;
    logic [cpe_pkg::NUM_PE-1:0] res_v;
    cpe_pkg::cpx_t              res_data [cpe_pkg::NUM_PE];
    logic [cpe_pkg::NUM_PE-1:0] active;
    logic                       pending;

    // sample stream into 16-word blocks
    cpe_sample_scatter u_scatter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_v  (sample_v),
        .sample    (sample),
        .load_v    (load_v),
        .load_data (load_data),
        .loading   (loading)
    );

    // program broadcast goes straight to every PE
    for (genvar g = 0; g < cpe_pkg::NUM_PE; g++) begin : g_pe
        cpe_pe u_pe (
            .clk       (clk),
            .rst_n     (rst_n),
            .load_v    (load_v[g]),
            .load_data (load_data),
            .inst_v    (inst_v),
            .inst      (inst),
            .res_v     (res_v[g]),
            .res_data  (res_data[g]),
            .active    (active[g])
        );
    end

    // results back to one tagged stream
    cpe_result_gather u_gather (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_v     (res_v),
        .res_data  (res_data),
        .result_v  (result_v),
        .result    (result),
        .result_pe (result_pe),
        .pending   (pending)
    );

    assign busy = loading | pending | (|active);

endmodule

`default_nettype wire

// ==== hdl/cpe_result_gather.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpe_result_gather (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [cpe_pkg::NUM_PE-1:0] res_v,
    input  cpe_pkg::cpx_t              res_data [cpe_pkg::NUM_PE],
    output logic                       result_v,
    output cpe_pkg::cpx_t              result,
    output cpe_pkg::pe_idx_t           result_pe,
    output logic                       pending
);

    // one FIFO per PE
    cpe_pkg::cpx_t fifo [cpe_pkg::NUM_PE][cpe_pkg::GATHER_DEPTH];

    logic [$clog2(cpe_pkg::GATHER_DEPTH)-1:0] wr_ptr [cpe_pkg::NUM_PE];
    logic [$clog2(cpe_pkg::GATHER_DEPTH)-1:0] rd_ptr [cpe_pkg::NUM_PE];
    // one extra bit so a full FIFO is countable
    logic [$clog2(cpe_pkg::GATHER_DEPTH):0]   count  [cpe_pkg::NUM_PE];

    logic [cpe_pkg::NUM_PE-1:0] empty;
    logic [cpe_pkg::NUM_PE-1:0] full;
    logic [cpe_pkg::NUM_PE-1:0] pop_vec;
    logic                       pop_any;
    cpe_pkg::pe_idx_t           pop_sel;
    // round-robin start point
    cpe_pkg::pe_idx_t           rr;

    always_comb begin
        for (int k = 0; k < cpe_pkg::NUM_PE; k++) begin
            empty[k] = (count[k] == '0);
            full[k]  = (count[k] == cpe_pkg::GATHER_DEPTH);
        end
    end

    ////////////////////////////////////////////////////////////
    // round-robin pick
    ////////////////////////////////////////////////////////////

    // first non-empty FIFO at or after rr
    always_comb begin
        cpe_pkg::pe_idx_t idx;
        pop_any = 1'b0;
        pop_sel = rr;
        for (int i = 0; i < cpe_pkg::NUM_PE; i++) begin
            idx = rr + cpe_pkg::pe_idx_t'(i);
            if (!pop_any && !empty[idx]) begin
                pop_any = 1'b1;
                pop_sel = idx;
            end
        end
        pop_vec = '0;
        if (pop_any) begin
            pop_vec[pop_sel] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // FIFO control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr       <= '0;
            result_v <= 1'b0;
            for (int k = 0; k < cpe_pkg::NUM_PE; k++) begin
                wr_ptr[k] <= '0;
                rd_ptr[k] <= '0;
                count[k]  <= '0;
            end
        end else begin
            result_v <= pop_any;
            // served PE goes to the back of the line
            if (pop_any) begin
                rr <= pop_sel + 1'b1;
            end
            for (int k = 0; k < cpe_pkg::NUM_PE; k++) begin
                if (res_v[k]) begin
                    wr_ptr[k] <= wr_ptr[k] + 1'b1;
                end
                if (pop_vec[k]) begin
                    rd_ptr[k] <= rd_ptr[k] + 1'b1;
                end
                count[k] <= count[k] + res_v[k] - pop_vec[k];
            end
        end
    end

    // storage and output payload
    always_ff @(posedge clk) begin
        for (int k = 0; k < cpe_pkg::NUM_PE; k++) begin
            if (res_v[k]) begin
                fifo[k][wr_ptr[k]] <= res_data[k];
            end
        end
        if (pop_any) begin
            result    <= fifo[pop_sel][rd_ptr[pop_sel]];
            result_pe <= pop_sel;
        end
    end

    // output register counts as still pending
    assign pending = ~(&empty) | result_v;

    // blocks only start with the array idle, so a PE never outruns its FIFO
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(|(res_v & full))
    ) else $error("result pushed into a full gather FIFO");

endmodule

`default_nettype wire

// ==== hdl/cpe_sample_scatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpe_sample_scatter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sample_v,
    input  cpe_pkg::cpx_t                sample,
    output logic [cpe_pkg::NUM_PE-1:0]   load_v,
    output cpe_pkg::cpx_t                load_data,
    output logic                         loading
);

    // position inside the current block
    cpe_pkg::addr_t  cnt;
    // PE receiving the current block
    cpe_pkg::pe_idx_t sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_v <= '0;
            cnt    <= '0;
            sel    <= '0;
        end else begin
            load_v <= '0;
            if (sample_v) begin
                load_v[sel] <= 1'b1;
                cnt         <= cnt + 1'b1;
                // 16th sample, next block goes to the next PE
                if (cnt == cpe_pkg::addr_t'(cpe_pkg::REG_NUM - 1)) begin
                    sel <= sel + 1'b1;
                end
            end
        end
    end

    // sample payload, shared by all PEs
    always_ff @(posedge clk) begin
        if (sample_v) begin
            load_data <= sample;
        end
    end

    // partial block, or a strobe still on its way out
    assign loading = (cnt != '0) | (|load_v);

endmodule

`default_nettype wire

// ==== hdl/cpe_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpe_pe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           load_v,
    input  cpe_pkg::cpx_t  load_data,
    input  logic           inst_v,
    input  cpe_pkg::inst_t inst,
    output logic           res_v,
    output cpe_pkg::cpx_t  res_data,
    output logic           active
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN
    } state_t;

    state_t         state;
    // next data word to fill during block load
    cpe_pkg::addr_t load_cnt;
    logic           start;

    // decoded current slot
    cpe_pkg::inst_t cur_inst;
    logic           last_slot;
    cpe_pkg::op_t   cur_op;
    logic           cur_emit;
    logic           cur_wb;
    cpe_pkg::addr_t src_a;
    cpe_pkg::addr_t src_b;
    cpe_pkg::addr_t dst;
    logic           halt;
    logic           hazard;
    logic           issue;

    // shadow of issued instructions, index 0 is the newest
    logic [cpe_pkg::ALU_LATENCY:0] fl_v;
    logic [cpe_pkg::ALU_LATENCY:0] fl_wb;
    logic [cpe_pkg::ALU_LATENCY:0] fl_emit;
    cpe_pkg::addr_t                fl_dst [cpe_pkg::ALU_LATENCY+1];
    cpe_pkg::op_t                  op_d;

    // data memory and ALU hookup
    logic           wb_now;
    logic           wren;
    cpe_pkg::addr_t waddr;
    cpe_pkg::cpx_t  wdata;
    cpe_pkg::cpx_t  rdata_a;
    cpe_pkg::cpx_t  rdata_b;
    logic           alu_v;
    cpe_pkg::cpx_t  alu_out;

    ////////////////////////////////////////////////////////////
    // decode and hazard check
    ////////////////////////////////////////////////////////////

    assign cur_op   = cur_inst[cpe_pkg::OP_LSB +: cpe_pkg::OP_WIDTH];
    assign cur_emit = cur_inst[cpe_pkg::EMIT_BIT];
    assign cur_wb   = cur_inst[cpe_pkg::WB_BIT];
    assign src_a    = cur_inst[cpe_pkg::SRC_A_LSB +: cpe_pkg::ADDR_WIDTH];
    assign src_b    = cur_inst[cpe_pkg::SRC_B_LSB +: cpe_pkg::ADDR_WIDTH];
    assign dst      = cur_inst[cpe_pkg::DST_LSB +: cpe_pkg::ADDR_WIDTH];
    assign halt     = (cur_op == cpe_pkg::OP_HALT);

    // any in-flight write-back to a source blocks issue
    always_comb begin
        hazard = 1'b0;
        for (int k = 0; k <= cpe_pkg::ALU_LATENCY; k++) begin
            if (fl_wb[k] && ((fl_dst[k] == src_a) || (fl_dst[k] == src_b))) begin
                hazard = 1'b1;
            end
        end
    end

    assign issue = (state == ST_RUN) && !halt && !hazard;

    // 16th sample of the block
    assign start = load_v && (load_cnt == cpe_pkg::addr_t'(cpe_pkg::REG_NUM - 1));

    ////////////////////////////////////////////////////////////
    // run state machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            load_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_LOAD: begin
                    if (load_v) begin
                        load_cnt <= load_cnt + 1'b1;
                        state    <= start ? ST_RUN : ST_LOAD;
                    end
                end
                default: begin
                    // halt or last slot issued
                    if (halt || (issue && last_slot)) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // valid, write-back and emit bits follow the ALU stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fl_v    <= '0;
            fl_wb   <= '0;
            fl_emit <= '0;
        end else begin
            fl_v    <= {fl_v[cpe_pkg::ALU_LATENCY-1:0], issue};
            fl_wb   <= {fl_wb[cpe_pkg::ALU_LATENCY-1:0], issue & cur_wb};
            fl_emit <= {fl_emit[cpe_pkg::ALU_LATENCY-1:0], issue & cur_emit};
        end
    end

    // payload side only matters under the valid bits
    always_ff @(posedge clk) begin
        op_d      <= cur_op;
        fl_dst[0] <= dst;
        for (int k = 1; k <= cpe_pkg::ALU_LATENCY; k++) begin
            fl_dst[k] <= fl_dst[k-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // write-back and emit
    ////////////////////////////////////////////////////////////

    assign wb_now   = alu_v & fl_wb[cpe_pkg::ALU_LATENCY];
    assign res_v    = alu_v & fl_emit[cpe_pkg::ALU_LATENCY];
    assign res_data = alu_out;

    // block load and write-back share the one write port
    assign wren  = load_v | wb_now;
    assign waddr = load_v ? load_cnt : fl_dst[cpe_pkg::ALU_LATENCY];
    assign wdata = load_v ? load_data : alu_out;

    // partial block, run, or results still in the pipe
    assign active = (state != ST_IDLE) | (|fl_v);

    cpe_inst_mem u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_v    (inst_v),
        .inst      (inst),
        .start     (start),
        .advance   (issue),
        .cur_inst  (cur_inst),
        .last_slot (last_slot)
    );

    cpe_data_mem u_dmem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wren    (wren),
        .waddr   (waddr),
        .wdata   (wdata),
        .rden    (issue),
        .raddr_a (src_a),
        .raddr_b (src_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    cpe_complex_alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .op_v   (fl_v[0]),
        .op     (op_d),
        .din_a  (rdata_a),
        .din_b  (rdata_b),
        .dout_v (alu_v),
        .dout   (alu_out)
    );

    // scatter must not refill a running PE
    a_no_load_in_run: assert property (
        @(posedge clk) disable iff (!rst_n) !(load_v && (state == ST_RUN))
    ) else $error("sample loaded while PE is running");

endmodule

`default_nettype wire

// ==== hdl/cpe_complex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpe_complex_alu (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          op_v,
    input  cpe_pkg::op_t  op,
    input  cpe_pkg::cpx_t din_a,
    input  cpe_pkg::cpx_t din_b,
    output logic          dout_v,
    output cpe_pkg::cpx_t dout
);

    // operand parts
    logic signed [cpe_pkg::DATA_WIDTH-1:0] a_re;
    logic signed [cpe_pkg::DATA_WIDTH-1:0] a_im;
    logic signed [cpe_pkg::DATA_WIDTH-1:0] b_re;
    logic signed [cpe_pkg::DATA_WIDTH-1:0] b_im;

    // stage one
    logic                                    v1;
    logic                                    mul1;
    logic signed [2*cpe_pkg::DATA_WIDTH-1:0] p_rr;
    logic signed [2*cpe_pkg::DATA_WIDTH-1:0] p_ii;
    logic signed [2*cpe_pkg::DATA_WIDTH-1:0] p_ri;
    logic signed [2*cpe_pkg::DATA_WIDTH-1:0] p_ir;
    logic        [cpe_pkg::DATA_WIDTH-1:0]   sum_re;
    logic        [cpe_pkg::DATA_WIDTH-1:0]   sum_im;

    // full precision multiply sums, one guard bit
    logic signed [2*cpe_pkg::DATA_WIDTH:0]   re_full;
    logic signed [2*cpe_pkg::DATA_WIDTH:0]   im_full;

    assign a_re = din_a[cpe_pkg::DATA_WIDTH +: cpe_pkg::DATA_WIDTH];
    assign a_im = din_a[0 +: cpe_pkg::DATA_WIDTH];
    assign b_re = din_b[cpe_pkg::DATA_WIDTH +: cpe_pkg::DATA_WIDTH];
    assign b_im = din_b[0 +: cpe_pkg::DATA_WIDTH];

    ////////////////////////////////////////////////////////////
    // stage one, partial products and part sums
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1 <= 1'b0;
        end else begin
            v1 <= op_v;
        end
    end

    always_ff @(posedge clk) begin
        if (op_v) begin
            mul1 <= (op == cpe_pkg::OP_MUL);
            p_rr <= a_re * b_re;
            p_ii <= a_im * b_im;
            p_ri <= a_re * b_im;
            p_ir <= a_im * b_re;
            // add and sub wrap at 16 bits
            if (op == cpe_pkg::OP_SUB) begin
                sum_re <= a_re - b_re;
                sum_im <= a_im - b_im;
            end else begin
                sum_re <= a_re + b_re;
                sum_im <= a_im + b_im;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stage two, combine, scale, truncate
    ////////////////////////////////////////////////////////////

    // (ar*br - ai*bi) and (ar*bi + ai*br)
    assign re_full = p_rr - p_ii;
    assign im_full = p_ri + p_ir;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_v <= 1'b0;
        end else begin
            dout_v <= v1;
        end
    end

    // slice at FRAC_BITS is the arithmetic shift, then low 16 bits kept
    always_ff @(posedge clk) begin
        if (v1) begin
            if (mul1) begin
                dout <= {re_full[cpe_pkg::FRAC_BITS +: cpe_pkg::DATA_WIDTH],
                         im_full[cpe_pkg::FRAC_BITS +: cpe_pkg::DATA_WIDTH]};
            end else begin
                dout <= {sum_re, sum_im};
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpe_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpe_data_mem (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wren,
    input  cpe_pkg::addr_t waddr,
    input  cpe_pkg::cpx_t  wdata,
    input  logic           rden,
    input  cpe_pkg::addr_t raddr_a,
    input  cpe_pkg::addr_t raddr_b,
    output cpe_pkg::cpx_t  rdata_a,
    output cpe_pkg::cpx_t  rdata_b
);

    // 16 complex words
    cpe_pkg::cpx_t regs [cpe_pkg::REG_NUM];

    // single write port, shared by block load and write-back
    always_ff @(posedge clk) begin
        if (wren) begin
            regs[waddr] <= wdata;
        end
    end

    // two registered read ports
    // no bypass, a write shows up one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_a <= '0;
            rdata_b <= '0;
        end else if (rden) begin
            rdata_a <= regs[raddr_a];
            rdata_b <= regs[raddr_b];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpe_inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpe_inst_mem (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           inst_v,
    input  cpe_pkg::inst_t inst,
    input  logic           start,
    input  logic           advance,
    output cpe_pkg::inst_t cur_inst,
    output logic           last_slot
);

    // program slots, no reset needed
    cpe_pkg::inst_t mem [cpe_pkg::IMEM_DEPTH];

    cpe_pkg::pc_t wptr;
    cpe_pkg::pc_t wslot;
    cpe_pkg::pc_t pc;
    logic         inst_v_d;

    // a load burst always begins at slot 0
    assign wslot = inst_v_d ? wptr : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr     <= '0;
            inst_v_d <= 1'b0;
        end else begin
            inst_v_d <= inst_v;
            if (inst_v) begin
                wptr <= wslot + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_v) begin
            mem[wslot] <= inst;
        end
    end

    // program counter
    // start wins over advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc + 1'b1;
        end
    end

    assign cur_inst  = mem[pc];
    assign last_slot = (pc == cpe_pkg::pc_t'(cpe_pkg::IMEM_DEPTH - 1));

    // broadcast program must not change under a running PE
    a_no_load_while_running: assert property (
        @(posedge clk) disable iff (!rst_n) !(inst_v && advance)
    ) else $error("instruction load while PE is issuing");

endmodule

`default_nettype wire

// ==== hdl/cpe_pkg.sv ====
`default_nettype none

package cpe_pkg;

    ////////////////////////////////////////////////////////////
    // array sizes
    ////////////////////////////////////////////////////////////

    // one real or imaginary part
    localparam int DATA_WIDTH   = 16;
    localparam int NUM_PE       = 4;
    // data words per PE, also samples per block
    localparam int REG_NUM      = 16;
    localparam int IMEM_DEPTH   = 8;
    // Q1.15 multiply scaling
    localparam int FRAC_BITS    = 15;
    // one slot per possible emit in a run
    localparam int GATHER_DEPTH = IMEM_DEPTH;
    // registered stages inside the complex ALU
    localparam int ALU_LATENCY  = 2;

    localparam int ADDR_WIDTH   = $clog2(REG_NUM);
    localparam int OP_WIDTH     = 2;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////

    // real part on top, imaginary below
    typedef logic [2*DATA_WIDTH-1:0]         cpx_t;
    typedef logic [$clog2(NUM_PE)-1:0]       pe_idx_t;
    typedef logic [ADDR_WIDTH-1:0]           addr_t;
    typedef logic [$clog2(IMEM_DEPTH)-1:0]   pc_t;
    typedef logic [OP_WIDTH-1:0]             op_t;
    typedef logic [OP_WIDTH+2+3*ADDR_WIDTH-1:0] inst_t;

    ////////////////////////////////////////////////////////////
    // instruction layout and opcodes
    ////////////////////////////////////////////////////////////

    // op | emit | wb | src a | src b | dst
    localparam int OP_LSB    = 2 + 3*ADDR_WIDTH;
    localparam int EMIT_BIT  = 1 + 3*ADDR_WIDTH;
    localparam int WB_BIT    = 3*ADDR_WIDTH;
    localparam int SRC_A_LSB = 2*ADDR_WIDTH;
    localparam int SRC_B_LSB = ADDR_WIDTH;
    localparam int DST_LSB   = 0;

    localparam op_t OP_HALT = 2'd0;
    localparam op_t OP_ADD  = 2'd1;
    localparam op_t OP_SUB  = 2'd2;
    localparam op_t OP_MUL  = 2'd3;

endpackage

`default_nettype wire
